// ==== commit/commit_stage.sv ====
`timescale 1ns/1ps

module commit_stage #(
    parameter core_pkg::word_t EXC_VECTOR = 32'hbfc00380
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       flush,
    input  core_pkg::exec_data_t [1:0] in,
    output logic                       finish,
    output core_pkg::wb_t [1:0]        out,
    output dmem_pkg::dmem_req_t        dmem_req,
    input  dmem_pkg::dmem_rsp_t        dmem_rsp,
    output core_pkg::redirect_t        redirect,
    output core_pkg::bypass_t          bypass0,
    output core_pkg::bypass_t          bypass1,
    input  logic [5:0]                 ext_int,
    output logic                       exception_valid,
    output core_pkg::exception_t       exception
);
    import core_pkg::*;

    exec_data_t [1:0] slots;
    exception_t       exc;
    logic             exc_valid;
    logic             int_pending;
    logic             finish_exc;
    logic             finish_data;
    logic             commit_eret;
    logic             mtc0_valid;
    word_t            mtc0_data;
    word_t            epc;

    assign finish = finish_exc & finish_data;

    // A flushed bundle is replaced upstream, so the request flag restarts too.
    exc_check i_exc_check (
        .clk, .arst_n,
        .advance     (finish | flush),
        .in,
        .int_pending,
        .addr_ok     (dmem_rsp.addr_ok),
        .dmem_req,
        .slots,
        .exc_valid,
        .exc,
        .finish_exc,
        .bypass0
    );

    cp0_regs i_cp0_regs (
        .clk, .arst_n,
        .ext_int,
        .commit_exc  (exception_valid),
        .exc         (exception),
        .commit_eret,
        .mtc0_valid,
        .mtc0_data,
        .int_pending,
        .epc
    );

    data_commit #(
        .EXC_VECTOR (EXC_VECTOR)
    ) i_data_commit (
        .clk, .arst_n,
        .flush,
        .advance     (finish),
        .slots,
        .exc_valid,
        .exc,
        .epc,
        .data_ok     (dmem_rsp.data_ok),
        .rdata       (dmem_rsp.rdata),
        .out,
        .bypass1,
        .redirect,
        .exception_valid,
        .exception,
        .commit_eret,
        .mtc0_valid,
        .mtc0_data,
        .finish_data
    );

endmodule

// ==== commit/cp0_regs.sv ====
`timescale 1ns/1ps

module cp0_regs (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [5:0]           ext_int,
    input  logic                 commit_exc,
    input  core_pkg::exception_t exc,
    input  logic                 commit_eret,
    input  logic                 mtc0_valid,
    input  core_pkg::word_t      mtc0_data,
    output logic                 int_pending,
    output core_pkg::word_t      epc
);
    import core_pkg::*;

    // IM, EXL and IE are the writable status fields.
    localparam word_t STATUS_WMASK = 32'h0000_ff03;

    word_t status;
    word_t cause;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            status <= '0;
            cause  <= '0;
        end
        else
        begin
            if (mtc0_valid)
                status <= (status & ~STATUS_WMASK) | (mtc0_data & STATUS_WMASK);
            if (commit_exc)
                status[1] <= 1'b1;          // EXL.
            else if (commit_eret)
                status[1] <= 1'b0;
            cause[15:10] <= ext_int;        // Hardware IP.
            if (commit_exc)
                cause[6:2] <= exc.code;
        end
    end

    always_ff @(posedge clk)
    begin
        if (commit_exc)
            epc <= exc.epc;
    end

    assign int_pending = status[0] & ~status[1] & (|(cause[15:8] & status[15:8]));

endmodule

// ==== commit/data_commit.sv ====
`timescale 1ns/1ps

module data_commit #(
    parameter core_pkg::word_t EXC_VECTOR = 32'hbfc00380
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       flush,
    input  logic                       advance,
    input  core_pkg::exec_data_t [1:0] slots,
    input  logic                       exc_valid,
    input  core_pkg::exception_t       exc,
    input  core_pkg::word_t            epc,
    input  logic                       data_ok,
    input  core_pkg::word_t            rdata,
    output core_pkg::wb_t [1:0]        out,
    output core_pkg::bypass_t          bypass1,
    output core_pkg::redirect_t        redirect,
    output logic                       exception_valid,
    output core_pkg::exception_t       exception,
    output logic                       commit_eret,
    output logic                       mtc0_valid,
    output core_pkg::word_t            mtc0_data,
    output logic                       finish_data
);
    import core_pkg::*;
    import dmem_pkg::*;

    exec_data_t [1:0] stage_slots;
    logic [1:0]       stage_valid;
    exception_t       stage_exc;
    logic             stage_exc_valid;
    logic [1:0]       is_load;
    logic             ld_sel;
    logic             stage_ld;
    logic             new_ld;
    logic             data_mine;
    logic             drain;        // Data owed to a dropped load.
    logic             eret_hit;
    logic             kill;
    logic [15:0]      ld_half;
    logic [7:0]       ld_byte;
    word_t            ld_word;

    assign is_load[0] = stage_valid[0] && (stage_slots[0].op == OP_LOAD);
    assign is_load[1] = stage_valid[1] && (stage_slots[1].op == OP_LOAD);
    assign ld_sel     = is_load[1];
    assign stage_ld   = |is_load;
    assign new_ld     = (slots[0].valid && (slots[0].op == OP_LOAD)) ||
                        (slots[1].valid && (slots[1].op == OP_LOAD));
    assign data_mine  = data_ok & ~drain;
    assign finish_data = ~stage_ld | data_mine;

    always_comb
    begin
        ld_half = stage_slots[ld_sel].addr[1] ? rdata[31:16] : rdata[15:0];
        ld_byte = stage_slots[ld_sel].addr[0] ? ld_half[15:8] : ld_half[7:0];
        case (stage_slots[ld_sel].mem_size)
            SIZE_BYTE: ld_word = {{24{stage_slots[ld_sel].mem_signed & ld_byte[7]}}, ld_byte};
            SIZE_HALF: ld_word = {{16{stage_slots[ld_sel].mem_signed & ld_half[15]}}, ld_half};
            default:   ld_word = rdata;
        endcase
    end

    always_comb
    begin
        bypass1     = '0;
        eret_hit    = 1'b0;
        mtc0_valid  = 1'b0;
        mtc0_data   = '0;
        redirect    = '0;
        for (int i = 0; i < 2; i++)
        begin
            out[i].valid = finish_data && stage_valid[i] && stage_slots[i].wen &&
                           (stage_slots[i].op inside {OP_ALU, OP_LOAD});
            out[i].dest  = stage_slots[i].dest;
            out[i].data  = is_load[i] ? ld_word : stage_slots[i].result;
            out[i].pc    = stage_slots[i].pc;
            if (out[i].valid)
                bypass1 = '{valid: 1'b1, dest: out[i].dest, data: out[i].data};
        end
        // Walk young to old so the oldest slot lands last.
        for (int i = 1; i >= 0; i--)
        begin
            if (stage_valid[i] && (stage_slots[i].op == OP_ERET))
                eret_hit = 1'b1;
            if (stage_valid[i] && (stage_slots[i].op == OP_MTC0))
            begin
                mtc0_valid = finish_data;
                mtc0_data  = stage_slots[i].wdata;
            end
            if (stage_valid[i] && stage_slots[i].redirect_valid)
                redirect = '{valid: 1'b1, pc: stage_slots[i].redirect_pc};
        end
        if (eret_hit)
            redirect = '{valid: 1'b1, pc: epc};
        if (stage_exc_valid)
            redirect = '{valid: 1'b1, pc: EXC_VECTOR};
        redirect.valid = redirect.valid & finish_data;
    end

    assign commit_eret     = eret_hit & finish_data;
    assign exception_valid = stage_exc_valid & finish_data;
    assign exception       = stage_exc;
    assign kill            = redirect.valid;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            stage_valid     <= 2'b00;
            stage_exc_valid <= 1'b0;
            drain           <= 1'b0;
        end
        else
        begin
            drain <= (drain & ~data_ok) | (flush & stage_ld & ~data_mine) |
                     (advance & (flush | kill) & new_ld);
            if (flush || kill)
            begin
                stage_valid     <= 2'b00;
                stage_exc_valid <= 1'b0;
            end
            else if (advance)
            begin
                stage_valid     <= {slots[1].valid, slots[0].valid};
                stage_exc_valid <= exc_valid;
            end
            else if (finish_data)
            begin
                stage_valid     <= 2'b00;   // Retired, nothing new behind it.
                stage_exc_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            stage_slots <= slots;
            stage_exc   <= exc;
        end
    end

    a_data_ok_owned: assert property (@(posedge clk) disable iff (!arst_n)
        data_ok |-> (stage_ld || drain));

endmodule

// ==== commit/exc_check.sv ====
`timescale 1ns/1ps

module exc_check (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       advance,
    input  core_pkg::exec_data_t [1:0] in,
    input  logic                       int_pending,
    input  logic                       addr_ok,
    output dmem_pkg::dmem_req_t        dmem_req,
    output core_pkg::exec_data_t [1:0] slots,
    output logic                       exc_valid,
    output core_pkg::exception_t       exc,
    output logic                       finish_exc,
    output core_pkg::bypass_t          bypass0
);
    import core_pkg::*;
    import dmem_pkg::*;

    logic [1:0]      misaligned;
    logic [1:0]      slot_exc;
    exc_code_t [1:0] slot_code;
    logic            first;
    logic [1:0]      mem_hit;
    logic            mem_sel;
    logic            accepted;

    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            misaligned[i] = ((in[i].mem_size == SIZE_HALF) && in[i].addr[0]) ||
                            ((in[i].mem_size == SIZE_WORD) && (in[i].addr[1:0] != 2'b00));
            slot_exc[i]  = in[i].valid;
            slot_code[i] = EXC_INT;
            if ((i == 0) && int_pending)
                slot_code[i] = EXC_INT;     // Interrupt rides on the oldest slot.
            else if ((in[i].op == OP_LOAD) && misaligned[i])
                slot_code[i] = EXC_ADEL;
            else if ((in[i].op == OP_STORE) && misaligned[i])
                slot_code[i] = EXC_ADES;
            else if ((in[i].op == OP_ALU) && in[i].overflow)
                slot_code[i] = EXC_OV;
            else if (in[i].op == OP_SYSCALL)
                slot_code[i] = EXC_SYS;
            else if (in[i].op == OP_BRK)
                slot_code[i] = EXC_BP;
            else
                slot_exc[i] = 1'b0;
        end
    end

    assign first         = ~slot_exc[0];
    assign exc_valid     = |slot_exc;
    assign exc.slot      = first;
    assign exc.code      = slot_code[first];
    assign exc.epc       = in[first].pc;
    assign exc.bad_vaddr = (slot_code[first] inside {EXC_ADEL, EXC_ADES}) ? in[first].addr : '0;

    // Faulting slot and everything younger are dropped.
    always_comb
    begin
        slots          = in;
        slots[0].valid = in[0].valid & ~slot_exc[0];
        slots[1].valid = in[1].valid & ~(|slot_exc);
    end

    assign mem_hit[0] = slots[0].valid && (slots[0].op inside {OP_LOAD, OP_STORE});
    assign mem_hit[1] = slots[1].valid && (slots[1].op inside {OP_LOAD, OP_STORE});
    assign mem_sel    = ~mem_hit[0];

    assign dmem_req.en    = (|mem_hit) & ~accepted;
    assign dmem_req.wt    = (slots[mem_sel].op == OP_STORE);
    assign dmem_req.size  = slots[mem_sel].mem_size;
    assign dmem_req.addr  = slots[mem_sel].addr;
    assign dmem_req.wdata = slots[mem_sel].wdata;

    assign finish_exc = ~(|mem_hit) | accepted | (dmem_req.en & addr_ok);

    // Request already taken, bundle still waiting on the data step.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            accepted <= 1'b0;
        else if (advance)
            accepted <= 1'b0;
        else if (dmem_req.en && addr_ok)
            accepted <= 1'b1;
    end

    // Slot 1 wins, it holds the newer value.
    always_comb
    begin
        bypass0 = '0;
        for (int i = 0; i < 2; i++)
        begin
            if (slots[i].valid && slots[i].wen && (slots[i].op == OP_ALU))
            begin
                bypass0.valid = 1'b1;
                bypass0.dest  = slots[i].dest;
                bypass0.data  = slots[i].result;
            end
        end
    end

    a_one_mem_op: assert property (@(posedge clk) disable iff (!arst_n)
        !(in[0].valid && in[1].valid &&
          (in[0].op inside {OP_LOAD, OP_STORE}) && (in[1].op inside {OP_LOAD, OP_STORE})));

    a_en_drops: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_req.en && addr_ok && !advance |=> !dmem_req.en);

endmodule

// ==== commit_stage.f ====
common/dmem_pkg.sv
common/core_pkg.sv
commit/exc_check.sv
commit/cp0_regs.sv
commit/data_commit.sv
commit/commit_stage.sv
dv/tb_commit_stage.sv

// ==== common/core_pkg.sv ====
package core_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [2:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_SYSCALL,
        OP_BRK,
        OP_ERET,
        OP_MTC0     // Writes status from wdata.
    } op_class_t;

    // MIPS cause codes.
    typedef enum logic [4:0] {
        EXC_INT  = 5'h00,
        EXC_ADEL = 5'h04,
        EXC_ADES = 5'h05,
        EXC_SYS  = 5'h08,
        EXC_BP   = 5'h09,
        EXC_OV   = 5'h0c
    } exc_code_t;

    typedef struct packed {
        logic            valid;
        word_t           pc;
        op_class_t       op;
        dmem_pkg::size_t mem_size;
        logic            mem_signed;
        word_t           addr;
        word_t           wdata;
        word_t           result;
        logic [4:0]      dest;
        logic            wen;
        logic            overflow;
        logic            redirect_valid;    // Branch resolved upstream.
        word_t           redirect_pc;
    } exec_data_t;

    typedef struct packed {
        exc_code_t code;
        word_t     epc;
        word_t     bad_vaddr;
        logic      slot;
    } exception_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] dest;
        word_t      data;
        word_t      pc;
    } wb_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] dest;
        word_t      data;
    } bypass_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
    } redirect_t;

endpackage

// ==== common/dmem_pkg.sv ====
package dmem_pkg;

    // Access size, as driven on the data-memory port.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } size_t;

    typedef struct packed {
        logic        en;    // Held until addr_ok.
        logic        wt;    // Store when set.
        size_t       size;
        logic [31:0] addr;
        logic [31:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;   // Loads only.
        logic [31:0] rdata;
    } dmem_rsp_t;

endpackage

// ==== dv/tb_commit_stage.sv ====
`timescale 1ns/1ps

module tb_commit_stage;
    import core_pkg::*;
    import dmem_pkg::*;

    typedef struct {
        exec_data_t [1:0] bundle;
        logic [5:0]       ext_int;
        wb_t [1:0]        exp_out;
        bypass_t          exp_byp0;
        logic             req_en;
        logic             req_wt;
        size_t            req_size;
        word_t            req_addr;
        word_t            req_wdata;
        logic             exc_en;
        exc_code_t        exc_code;
        logic             exc_slot;
        word_t            exc_epc;
        word_t            exc_badv;
        redirect_t        redir;
    } row_t;

    logic                clk;
    logic                arst_n;
    logic                flush;
    exec_data_t [1:0]    in;
    logic                finish;
    wb_t [1:0]           out;
    dmem_req_t           dmem_req;
    dmem_rsp_t           dmem_rsp = '0;
    redirect_t           redirect;
    bypass_t             bypass0;
    bypass_t             bypass1;
    logic [5:0]          ext_int;
    logic                exception_valid;
    exception_t          exception;

    row_t                tbl[$];
    string               names[$];
    int                  errors = 0;
    int                  failed_tests = 0;
    int                  cycles = 0;
    int                  limit = 1000;
    integer              seed = 32'h29e09276;
    logic [1:0]          a_wait;
    logic [1:0]          d_wait;
    logic                d_pend;
    word_t               d_addr;

    commit_stage i_dut (
        .clk, .arst_n, .flush, .in, .finish, .out, .dmem_req, .dmem_rsp,
        .redirect, .bypass0, .bypass1, .ext_int, .exception_valid, .exception
    );

    always #5 clk = ~clk;

    // Read word is the address XOR 32'h5a5a0000.
    always @(posedge clk or negedge arst_n)
    begin : responder
        int pick;
        if (!arst_n)
        begin
            dmem_rsp <= '{addr_ok: 1'b1, data_ok: 1'b0, rdata: '0};
            a_wait   <= '0;
            d_wait   <= '0;
            d_pend   <= 1'b0;
            d_addr   <= '0;
        end
        else
        begin
            dmem_rsp.data_ok <= 1'b0;
            if (dmem_req.en && dmem_rsp.addr_ok)
            begin
                pick = {$random(seed)} % 3;
                a_wait           <= pick[1:0];
                dmem_rsp.addr_ok <= (pick == 0);
                if (!dmem_req.wt)
                begin
                    pick = {$random(seed)} % 3;
                    d_pend <= 1'b1;
                    d_wait <= 2'd1 + pick[1:0];
                    d_addr <= dmem_req.addr;
                end
            end
            else if (a_wait != 0)
            begin
                a_wait           <= a_wait - 2'd1;
                dmem_rsp.addr_ok <= (a_wait == 2'd1);
            end
            if (d_pend)
            begin
                if (d_wait == 2'd1)
                begin
                    dmem_rsp.data_ok <= 1'b1;
                    dmem_rsp.rdata   <= d_addr ^ 32'h5a5a0000;
                    d_pend           <= 1'b0;
                end
                else
                    d_wait <= d_wait - 2'd1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles > limit)
        begin
            $display("timeout: stage did not finish within %0d cycles", limit);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic exec_data_t make_alu(word_t pc, logic [4:0] dest, word_t res);
        exec_data_t s;
        s        = '0;
        s.valid  = 1'b1;
        s.pc     = pc;
        s.op     = OP_ALU;
        s.dest   = dest;
        s.result = res;
        s.wen    = 1'b1;
        return s;
    endfunction

    function automatic exec_data_t make_op(op_class_t op, word_t pc, size_t sz, logic sgn,
                                           word_t addr, word_t wdata, logic [4:0] dest);
        exec_data_t s;
        s            = '0;
        s.valid      = 1'b1;
        s.pc         = pc;
        s.op         = op;
        s.mem_size   = sz;
        s.mem_signed = sgn;
        s.addr       = addr;
        s.wdata      = wdata;
        s.dest       = dest;
        s.wen        = (op == OP_LOAD);
        return s;
    endfunction

    function automatic wb_t wb_of(exec_data_t s, word_t data);
        return '{valid: 1'b1, dest: s.dest, data: data, pc: s.pc};
    endfunction

    // Expected load value picked from the responder word by byte lane.
    function automatic word_t load_value(word_t addr, size_t sz, logic sgn);
        word_t w;
        w = (addr ^ 32'h5a5a0000) >> {addr[1:0], 3'b000};
        if (sz == SIZE_BYTE)
            return sgn ? {{24{w[7]}}, w[7:0]} : {24'h0, w[7:0]};
        if (sz == SIZE_HALF)
            return sgn ? {{16{w[15]}}, w[15:0]} : {16'h0, w[15:0]};
        return addr ^ 32'h5a5a0000;
    endfunction

    function automatic row_t blank_row();
        row_t r;
        r.bundle    = '0;
        r.ext_int   = '0;
        r.exp_out   = '0;
        r.exp_byp0  = '0;
        r.req_en    = 1'b0;
        r.req_wt    = 1'b0;
        r.req_size  = SIZE_BYTE;
        r.req_addr  = '0;
        r.req_wdata = '0;
        r.exc_en    = 1'b0;
        r.exc_code  = EXC_INT;
        r.exc_slot  = 1'b0;
        r.exc_epc   = '0;
        r.exc_badv  = '0;
        r.redir     = '0;
        return r;
    endfunction

    task automatic add_exc(input string name, input row_t r, input exc_code_t code,
                           input logic slot, input word_t epc, input word_t badv);
        r.exc_en   = 1'b1;
        r.exc_code = code;
        r.exc_slot = slot;
        r.exc_epc  = epc;
        r.exc_badv = badv;
        r.redir    = '{valid: 1'b1, pc: 32'hbfc00380};
        tbl.push_back(r);
        names.push_back(name);
    endtask

    task automatic build_table();
        row_t        r;
        exec_data_t  a0;
        exec_data_t  a1;
        word_t       addr;
        size_t       sizes[3];
        sizes = '{SIZE_BYTE, SIZE_HALF, SIZE_WORD};
        a0 = make_alu(32'h100, 5'd1, 32'h1111_1111);
        a1 = make_alu(32'h104, 5'd2, 32'h2222_2222);
        r = blank_row();
        r.bundle   = {a1, a0};
        r.exp_out  = {wb_of(a1, a1.result), wb_of(a0, a0.result)};
        r.exp_byp0 = '{valid: 1'b1, dest: 5'd2, data: a1.result};
        tbl.push_back(r);
        names.push_back("alu pair");
        // Every size, sign and legal offset.
        for (int sz = 0; sz < 3; sz++)
        begin
            for (int sgn = 0; sgn < 2; sgn++)
            begin
                for (int off = 0; off < 4; off += (1 << sz))
                begin
                    if ((sz == 2) && (sgn == 1))
                        continue;
                    addr = 32'h1000_80f0 + off;
                    r = blank_row();
                    r.bundle[0]  = make_op(OP_LOAD, 32'h200 + 4 * off, sizes[sz], sgn[0],
                                           addr, '0, 5'd7);
                    r.exp_out[0] = wb_of(r.bundle[0], load_value(addr, sizes[sz], sgn[0]));
                    r.req_en     = 1'b1;
                    r.req_size   = sizes[sz];
                    r.req_addr   = addr;
                    tbl.push_back(r);
                    names.push_back($sformatf("load size %0d signed %0d off %0d",
                                              sz, sgn, off));
                end
            end
        end
        r = blank_row();
        r.bundle     = {make_op(OP_STORE, 32'h304, SIZE_WORD, 1'b0, 32'h2000_0010,
                                32'hcafe_f00d, 5'd0), make_alu(32'h300, 5'd3, 32'h33)};
        r.exp_out[0] = wb_of(r.bundle[0], 32'h33);
        r.exp_byp0   = '{valid: 1'b1, dest: 5'd3, data: 32'h33};
        r.req_en     = 1'b1;
        r.req_wt     = 1'b1;
        r.req_size   = SIZE_WORD;
        r.req_addr   = 32'h2000_0010;
        r.req_wdata  = 32'hcafe_f00d;
        tbl.push_back(r);
        names.push_back("store word slot 1");
        r = blank_row();
        r.bundle[0]  = make_op(OP_STORE, 32'h310, SIZE_BYTE, 1'b0, 32'h2000_0013,
                               32'h0000_00a5, 5'd0);
        r.req_en     = 1'b1;
        r.req_wt     = 1'b1;
        r.req_addr   = 32'h2000_0013;
        r.req_wdata  = 32'h0000_00a5;
        tbl.push_back(r);
        names.push_back("store byte slot 0");
        r = blank_row();
        r.bundle = {make_alu(32'h404, 5'd4, 32'h44),
                    make_op(OP_LOAD, 32'h400, SIZE_WORD, 1'b0, 32'h3000_0002, '0, 5'd8)};
        add_exc("misaligned load slot 0", r, EXC_ADEL, 1'b0, 32'h400, 32'h3000_0002);
        r = blank_row();
        r.bundle     = {make_op(OP_LOAD, 32'h414, SIZE_HALF, 1'b1, 32'h3000_0001, '0, 5'd9),
                        make_alu(32'h410, 5'd4, 32'h45)};
        r.exp_out[0] = wb_of(r.bundle[0], 32'h45);
        r.exp_byp0   = '{valid: 1'b1, dest: 5'd4, data: 32'h45};
        add_exc("misaligned load slot 1", r, EXC_ADEL, 1'b1, 32'h414, 32'h3000_0001);
        r.bundle[1]          = make_alu(32'h424, 5'd6, 32'h66);
        r.bundle[1].overflow = 1'b1;
        add_exc("overflow slot 1", r, EXC_OV, 1'b1, 32'h424, '0);
        r.bundle[1] = make_op(OP_SYSCALL, 32'h434, SIZE_BYTE, 1'b0, '0, '0, 5'd0);
        add_exc("syscall slot 1", r, EXC_SYS, 1'b1, 32'h434, '0);
        r.bundle[1] = make_op(OP_BRK, 32'h444, SIZE_BYTE, 1'b0, '0, '0, 5'd0);
        add_exc("break slot 1", r, EXC_BP, 1'b1, 32'h444, '0);
        // Sets IE and IM[2] while ext_int[0] drives IP[2].
        r = blank_row();
        r.bundle[0] = make_op(OP_MTC0, 32'h480, SIZE_BYTE, 1'b0, '0, 32'h0000_0401, 5'd0);
        r.ext_int   = 6'd1;
        tbl.push_back(r);
        names.push_back("mtc0 enables interrupt");
        r = blank_row();
        r.bundle[0] = make_alu(32'h500, 5'd5, 32'h55);
        r.ext_int   = 6'd1;
        add_exc("interrupt on slot 0", r, EXC_INT, 1'b0, 32'h500, '0);
        r = blank_row();
        r.bundle[0] = make_op(OP_ERET, 32'h600, SIZE_BYTE, 1'b0, '0, '0, 5'd0);
        r.redir     = '{valid: 1'b1, pc: 32'h500};
        tbl.push_back(r);
        names.push_back("eret to epc");
    endtask

    initial
    begin
        row_t       r;
        bypass_t    exp_b1;
        int         e0;
        logic       req_seen;
        dmem_req_t  req_cap;
        clk     = 1'b0;
        arst_n  = 1'b0;
        flush   = 1'b0;
        in      = '0;
        ext_int = '0;
        build_table();
        limit = tbl.size() * 12 + 20;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        for (int n = 0; n < tbl.size(); n++)
        begin
            r  = tbl[n];
            e0 = errors;
            req_seen = 1'b0;
            req_cap  = '0;
            @(posedge clk);
            in      <= r.bundle;
            ext_int <= r.ext_int;
            do
            begin
                @(negedge clk);
                if (dmem_req.en)
                begin
                    req_seen = 1'b1;
                    req_cap  = dmem_req;
                end
            end while (!finish);
            check("bypass0.valid", r.exp_byp0.valid, bypass0.valid);
            if (r.exp_byp0.valid)
            begin
                check("bypass0.dest", r.exp_byp0.dest, bypass0.dest);
                check("bypass0.data", r.exp_byp0.data, bypass0.data);
            end
            check("dmem_req.en", r.req_en, req_seen);
            if (r.req_en)
            begin
                check("dmem_req.wt", r.req_wt, req_cap.wt);
                check("dmem_req.size", r.req_size, req_cap.size);
                check("dmem_req.addr", r.req_addr, req_cap.addr);
                if (r.req_wt)
                    check("dmem_req.wdata", r.req_wdata, req_cap.wdata);
            end
            // Behind a redirect a live bundle follows, and it must be dropped.
            @(posedge clk);
            in <= r.redir.valid ? {make_alu(32'h900, 5'd30, 32'hdead),
                                   make_alu(32'h8fc, 5'd29, 32'hbeef)} : '0;
            do
                @(negedge clk);
            while (!finish);
            exp_b1 = '0;
            for (int i = 0; i < 2; i++)
            begin
                check($sformatf("out[%0d].valid", i), r.exp_out[i].valid, out[i].valid);
                if (r.exp_out[i].valid)
                begin
                    check($sformatf("out[%0d].dest", i), r.exp_out[i].dest, out[i].dest);
                    check($sformatf("out[%0d].data", i), r.exp_out[i].data, out[i].data);
                    check($sformatf("out[%0d].pc", i), r.exp_out[i].pc, out[i].pc);
                    exp_b1 = '{valid: 1'b1, dest: r.exp_out[i].dest, data: r.exp_out[i].data};
                end
            end
            check("bypass1.valid", exp_b1.valid, bypass1.valid);
            if (exp_b1.valid)
            begin
                check("bypass1.dest", exp_b1.dest, bypass1.dest);
                check("bypass1.data", exp_b1.data, bypass1.data);
            end
            check("redirect.valid", r.redir.valid, redirect.valid);
            if (r.redir.valid)
                check("redirect.pc", r.redir.pc, redirect.pc);
            check("exception_valid", r.exc_en, exception_valid);
            if (r.exc_en)
            begin
                check("exception.code", r.exc_code, exception.code);
                check("exception.slot", r.exc_slot, exception.slot);
                check("exception.epc", r.exc_epc, exception.epc);
                check("exception.bad_vaddr", r.exc_badv, exception.bad_vaddr);
            end
            @(posedge clk);
            in <= '0;
            @(negedge clk);
            check("out[0].valid", 1'b0, out[0].valid);
            check("out[1].valid", 1'b0, out[1].valid);
            check("redirect.valid", 1'b0, redirect.valid);
            check("exception_valid", 1'b0, exception_valid);
            if (errors != e0)
                failed_tests++;
            $display("test %0d %s: %s", n, names[n], (errors == e0) ? "ok" : "FAILED");
        end
        $display("%0d tests run, %0d failing, %0d mismatches",
                 tbl.size(), failed_tests, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_commit_stage \
    -f commit_stage.f -o sim_commit_stage
result=$(./obj_dir/sim_commit_stage)
echo "$result"
if echo "$result" | grep -q "all tests passed"; then
    exit 0
else
    exit 1
fi
